//--- design/pkt_buffer_params.svh
`ifndef PKT_BUFFER_PARAMS_SVH
`define PKT_BUFFER_PARAMS_SVH

//////////////////////////////////////////////////////////////
// store geometry
//////////////////////////////////////////////////////////////
`define PB_DEPTH        256
`define PB_ADDR_W       8
`define PB_DATA_W       24
`define PB_KEEP_W       3     // one per data byte
`define PB_META_W       32
`define PB_PIFO_W       16

//////////////////////////////////////////////////////////////
// apb map: [11:10] region, [9:2] index
//////////////////////////////////////////////////////////////
`define PB_APB_AW       12
`define PB_APB_DW       32
`define PB_REGION_HI    11
`define PB_REGION_LO    10
`define PB_INDEX_HI     9
`define PB_INDEX_LO     2

`define PB_REGION_PKT   2'd0
`define PB_REGION_META  2'd1
`define PB_REGION_PIFO  2'd2  // region 3 unmapped

`endif

//--- design/pkt_buffer_pkg.sv
`include "pkt_buffer_params.svh"
`default_nettype none

package pkt_buffer_pkg;

    // one packet beat, last on top
    typedef struct packed {
        logic                  last;
        logic [`PB_KEEP_W-1:0] keep;
        logic [`PB_DATA_W-1:0] data;
    } pkt_word_t;

    // one buffer slot across all three stores
    typedef struct packed {
        pkt_word_t             pkt;
        logic [`PB_META_W-1:0] meta;
        logic [`PB_PIFO_W-1:0] pifo;
    } buf_entry_t;

    // encodings follow the apb region codes
    typedef enum logic [1:0] {
        SEL_PKT  = `PB_REGION_PKT,
        SEL_META = `PB_REGION_META,
        SEL_PIFO = `PB_REGION_PIFO,
        SEL_NONE = 2'd3
    } buf_sel_t;

    typedef struct packed {
        logic                  valid;
        buf_sel_t              sel;
        logic                  we;
        logic [`PB_ADDR_W-1:0] index;
        logic [`PB_APB_DW-1:0] wdata;
    } cpu_req_t;

endpackage

`default_nettype wire

//--- design/buffer_ram.sv
`include "pkt_buffer_params.svh"
`timescale 1ns/1ps
`default_nettype none

module buffer_ram #(
    parameter int WIDTH = 32
) (
    input  logic                  clk,
    // port a, read/write
    input  logic                  a_en,
    input  logic                  a_we,
    input  logic [`PB_ADDR_W-1:0] a_addr,
    input  logic [WIDTH-1:0]      a_din,
    output logic [WIDTH-1:0]      a_dout,
    // port b, read only
    input  logic [`PB_ADDR_W-1:0] b_addr,
    output logic [WIDTH-1:0]      b_dout
);

    logic [WIDTH-1:0] mem [`PB_DEPTH];

    always_ff @(posedge clk)
    begin
        if (a_en)
        begin
            if (a_we)
                mem[a_addr] <= a_din;
            a_dout <= mem[a_addr];  // old word on write
        end
    end

    always_ff @(posedge clk)
    begin
        b_dout <= mem[b_addr];  // read-first against port a
    end

    //////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////
    a_we_needs_en: assert property (@(posedge clk) a_we |-> a_en)
        else $error("buffer_ram: port a write without enable");

endmodule

`default_nettype wire

//--- design/buffer_store.sv
`include "pkt_buffer_params.svh"
`timescale 1ns/1ps
`default_nettype none

module buffer_store
    import pkt_buffer_pkg::*;
(
    input  logic                  clk,
    input  logic                  rstn,
    // data path write
    input  logic                  wr_en,
    input  logic [`PB_ADDR_W-1:0] wr_addr,
    input  buf_entry_t            wr_entry,
    // data path read
    input  logic [`PB_ADDR_W-1:0] rd_addr,
    output buf_entry_t            rd_entry,
    // cpu side
    input  cpu_req_t              cpu_req,
    output logic                  cpu_grant,
    output logic [`PB_APB_DW-1:0] cpu_rdata
);

    localparam int PKT_W = $bits(pkt_word_t);
    localparam int DW    = `PB_APB_DW;

    logic [`PB_ADDR_W-1:0] a_addr;
    logic                  pkt_en;
    logic                  pkt_we;
    logic                  meta_en;
    logic                  meta_we;
    logic                  pifo_en;
    logic                  pifo_we;
    logic [PKT_W-1:0]      pkt_din;
    logic [PKT_W-1:0]      pkt_dout;
    logic [`PB_META_W-1:0] meta_din;
    logic [`PB_META_W-1:0] meta_dout;
    logic [`PB_PIFO_W-1:0] pifo_din;
    logic [`PB_PIFO_W-1:0] pifo_dout;
    pkt_word_t             pkt_rd;
    logic [`PB_META_W-1:0] meta_rd;
    logic [`PB_PIFO_W-1:0] pifo_rd;
    buf_sel_t              sel_q;

    //////////////////////////////////////////////////////////////
    // port a arbitration, data path first
    //////////////////////////////////////////////////////////////
    assign cpu_grant = cpu_req.valid && !wr_en;

    always_comb
    begin
        a_addr   = wr_addr;
        pkt_din  = wr_entry.pkt;
        meta_din = wr_entry.meta;
        pifo_din = wr_entry.pifo;
        pkt_en   = wr_en;
        meta_en  = wr_en;
        pifo_en  = wr_en;
        pkt_we   = wr_en;
        meta_we  = wr_en;
        pifo_we  = wr_en;
        if (cpu_grant)
        begin
            // only the selected store sees the access
            a_addr   = cpu_req.index;
            pkt_din  = cpu_req.wdata[PKT_W-1:0];
            meta_din = cpu_req.wdata[`PB_META_W-1:0];
            pifo_din = cpu_req.wdata[`PB_PIFO_W-1:0];
            pkt_en   = (cpu_req.sel == SEL_PKT);
            meta_en  = (cpu_req.sel == SEL_META);
            pifo_en  = (cpu_req.sel == SEL_PIFO);
            pkt_we   = pkt_en && cpu_req.we;
            meta_we  = meta_en && cpu_req.we;
            pifo_we  = pifo_en && cpu_req.we;
        end
    end

    buffer_ram #(.WIDTH(PKT_W)) pkt_ram (
        .clk(clk), .a_en(pkt_en), .a_we(pkt_we), .a_addr(a_addr),
        .a_din(pkt_din), .a_dout(pkt_dout), .b_addr(rd_addr), .b_dout(pkt_rd)
    );

    buffer_ram #(.WIDTH(`PB_META_W)) meta_ram (
        .clk(clk), .a_en(meta_en), .a_we(meta_we), .a_addr(a_addr),
        .a_din(meta_din), .a_dout(meta_dout), .b_addr(rd_addr), .b_dout(meta_rd)
    );

    buffer_ram #(.WIDTH(`PB_PIFO_W)) pifo_ram (
        .clk(clk), .a_en(pifo_en), .a_we(pifo_we), .a_addr(a_addr),
        .a_din(pifo_din), .a_dout(pifo_dout), .b_addr(rd_addr), .b_dout(pifo_rd)
    );

    assign rd_entry = '{pkt: pkt_rd, meta: meta_rd, pifo: pifo_rd};

    //////////////////////////////////////////////////////////////
    // cpu read return, one cycle after grant
    //////////////////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (!rstn)
            sel_q <= SEL_NONE;
        else if (cpu_grant)
            sel_q <= cpu_req.sel;
    end

    always_comb
    begin
        case (sel_q)
            SEL_PKT:  cpu_rdata = DW'(pkt_dout);   // upper bits zero
            SEL_META: cpu_rdata = meta_dout;
            SEL_PIFO: cpu_rdata = DW'(pifo_dout);
            default:  cpu_rdata = '0;
        endcase
    end

    // a granted access must land on one of the three rams
    grant_to_mapped_store: assert property (
        @(posedge clk) disable iff (!rstn) cpu_grant |-> cpu_req.sel != SEL_NONE
    ) else $error("buffer_store: cpu grant without a mapped store");

endmodule

`default_nettype wire

//--- design/cpu_access_ctrl.sv
`include "pkt_buffer_params.svh"
`timescale 1ns/1ps
`default_nettype none

module cpu_access_ctrl
    import pkt_buffer_pkg::*;
(
    input  logic                  clk,
    input  logic                  rstn,
    // apb slave
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [`PB_APB_AW-1:0] paddr,
    input  logic [`PB_APB_DW-1:0] pwdata,
    output logic [`PB_APB_DW-1:0] prdata,
    output logic                  pready,
    output logic                  pslverr,
    // towards the store
    output cpu_req_t              cpu_req,
    input  logic                  cpu_grant,
    input  logic [`PB_APB_DW-1:0] cpu_rdata
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_DONE
    } state_t;

    state_t                state;
    state_t                state_nxt;
    buf_sel_t              addr_sel;
    logic                  unmapped;
    buf_sel_t              req_sel;
    logic                  req_we;
    logic [`PB_ADDR_W-1:0] req_index;
    logic [`PB_APB_DW-1:0] req_wdata;

    //////////////////////////////////////////////////////////////
    // address decode
    //////////////////////////////////////////////////////////////
    assign addr_sel = buf_sel_t'(paddr[`PB_REGION_HI:`PB_REGION_LO]);
    assign unmapped = (addr_sel == SEL_NONE);

    always_comb
    begin
        state_nxt = state;
        case (state)
            ST_IDLE:
                if (psel && !penable && !unmapped)
                    state_nxt = ST_REQ;   // setup phase
            ST_REQ:
                if (cpu_grant)
                    state_nxt = ST_DONE;
            ST_DONE:
                state_nxt = ST_IDLE;
            default:
                state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rstn)
            state <= ST_IDLE;
        else
            state <= state_nxt;
    end

    // request payload, held while waiting
    always_ff @(posedge clk)
    begin
        if (state == ST_IDLE && psel && !penable)
        begin
            req_sel   <= addr_sel;
            req_we    <= pwrite;
            req_index <= paddr[`PB_INDEX_HI:`PB_INDEX_LO];
            req_wdata <= pwdata;
        end
    end

    assign cpu_req = '{
        valid: (state == ST_REQ),
        sel:   req_sel,
        we:    req_we,
        index: req_index,
        wdata: req_wdata
    };

    //////////////////////////////////////////////////////////////
    // apb response
    //////////////////////////////////////////////////////////////
    always_comb
    begin
        pready  = 1'b0;
        pslverr = 1'b0;
        prdata  = '0;
        if (state == ST_DONE)
        begin
            pready = 1'b1;
            if (!req_we)
                prdata = cpu_rdata;  // port a output this cycle
        end
        else if (state == ST_IDLE && psel && penable && unmapped)
        begin
            pready  = 1'b1;  // region 3, no store access
            pslverr = 1'b1;
        end
    end

    pready_in_access: assert property (
        @(posedge clk) disable iff (!rstn) pready |-> psel && penable
    ) else $error("cpu_access_ctrl: pready outside access phase");

    req_held_until_grant: assert property (
        @(posedge clk) disable iff (!rstn)
        cpu_req.valid && !cpu_grant |=> cpu_req.valid && $stable(cpu_req)
    ) else $error("cpu_access_ctrl: request changed before grant");

endmodule

`default_nettype wire

//--- design/pkt_buffer_top.sv
`include "pkt_buffer_params.svh"
`timescale 1ns/1ps
`default_nettype none

module pkt_buffer_top
    import pkt_buffer_pkg::*;
(
    input  logic                  clk,
    input  logic                  rstn,
    // data path write
    input  logic                  wr_en,
    input  logic [`PB_ADDR_W-1:0] wr_addr,
    input  buf_entry_t            wr_entry,
    // data path read, fixed one cycle
    input  logic [`PB_ADDR_W-1:0] rd_addr,
    output buf_entry_t            rd_entry,
    // apb slave
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [`PB_APB_AW-1:0] paddr,
    input  logic [`PB_APB_DW-1:0] pwdata,
    output logic [`PB_APB_DW-1:0] prdata,
    output logic                  pready,
    output logic                  pslverr
);

    cpu_req_t              cpu_req;
    logic                  cpu_grant;
    logic [`PB_APB_DW-1:0] cpu_rdata;

    cpu_access_ctrl cpu_ctrl (
        .clk       (clk),
        .rstn      (rstn),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .cpu_req   (cpu_req),
        .cpu_grant (cpu_grant),
        .cpu_rdata (cpu_rdata)
    );

    // stores plus port a arbiter
    buffer_store store (
        .clk       (clk),
        .rstn      (rstn),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_entry  (wr_entry),
        .rd_addr   (rd_addr),
        .rd_entry  (rd_entry),
        .cpu_req   (cpu_req),
        .cpu_grant (cpu_grant),
        .cpu_rdata (cpu_rdata)
    );

endmodule

`default_nettype wire

//--- tb/pkt_buffer_tb.sv
`include "pkt_buffer_params.svh"
`timescale 1ns/1ps
`default_nettype none

module pkt_buffer_tb
    import pkt_buffer_pkg::*;
();

    localparam int APB_TIMEOUT = 64;

    logic                  clk;
    logic                  rstn;
    logic                  wr_en;
    logic [`PB_ADDR_W-1:0] wr_addr;
    buf_entry_t            wr_entry;
    logic [`PB_ADDR_W-1:0] rd_addr;
    buf_entry_t            rd_entry;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [`PB_APB_AW-1:0] paddr;
    logic [`PB_APB_DW-1:0] pwdata;
    logic [`PB_APB_DW-1:0] prdata;
    logic                  pready;
    logic                  pslverr;

    integer seed   = 32'h9e62_cac0;

    // shadow of the three stores
    logic [`PB_DATA_W-1:0] data_m [`PB_DEPTH];
    logic [`PB_KEEP_W-1:0] keep_m [`PB_DEPTH];
    logic                  last_m [`PB_DEPTH];
    logic [`PB_META_W-1:0] meta_m [`PB_DEPTH];
    logic [`PB_PIFO_W-1:0] pifo_m [`PB_DEPTH];

    pkt_buffer_top UUT (
        .clk(clk), .rstn(rstn),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_entry(wr_entry),
        .rd_addr(rd_addr), .rd_entry(rd_entry),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    //////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at %0t while waiting for %s", $time, what);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("ERROR at %0t: %s = %h, expected %h", $time, name, actual, expected);
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    task automatic random_entry(output buf_entry_t e);
        e.pkt.data = $random(seed);
        e.pkt.keep = $random(seed);
        e.pkt.last = $random(seed);
        e.meta     = $random(seed);
        e.pifo     = $random(seed);
    endtask

    // zero-extended cpu view of one slot
    function automatic logic [31:0] expected_word(input logic [1:0] region,
                                                  input logic [7:0] idx);
        case (region)
            `PB_REGION_PKT:  return {4'b0, last_m[idx], keep_m[idx], data_m[idx]};
            `PB_REGION_META: return meta_m[idx];
            default:         return {16'b0, pifo_m[idx]};
        endcase
    endfunction

    task automatic apply_cpu_write(input logic [1:0] region, input logic [7:0] idx,
                                   input logic [31:0] w);
        case (region)
            `PB_REGION_PKT:
            begin
                last_m[idx] = w[27];
                keep_m[idx] = w[26:24];
                data_m[idx] = w[23:0];
            end
            `PB_REGION_META: meta_m[idx] = w;
            `PB_REGION_PIFO: pifo_m[idx] = w[15:0];  // upper half dropped
            default: ;
        endcase
    endtask

    //////////////////////////////////////////////////////////////
    // data path
    //////////////////////////////////////////////////////////////
    task automatic dp_write(input logic [7:0] addr, input buf_entry_t e);
        step();
        wr_en        = 1'b1;
        wr_addr      = addr;
        wr_entry     = e;
        data_m[addr] = e.pkt.data;
        keep_m[addr] = e.pkt.keep;
        last_m[addr] = e.pkt.last;
        meta_m[addr] = e.meta;
        pifo_m[addr] = e.pifo;
    endtask

    task automatic dp_release();
        step();
        wr_en = 1'b0;
    endtask

    task automatic dp_read_check(input logic [7:0] addr);
        step();
        rd_addr = addr;
        @(posedge clk);  // address sampled here
        @(negedge clk);
        check_value("rd_entry.pkt.data", rd_entry.pkt.data, data_m[addr]);
        check_value("rd_entry.pkt.keep", rd_entry.pkt.keep, keep_m[addr]);
        check_value("rd_entry.pkt.last", rd_entry.pkt.last, last_m[addr]);
        check_value("rd_entry.meta", rd_entry.meta, meta_m[addr]);
        check_value("rd_entry.pifo", rd_entry.pifo, pifo_m[addr]);
    endtask

    task automatic check_all_entries();
        for (int i = 0; i < `PB_DEPTH; i++)
            dp_read_check(i);
    endtask

    //////////////////////////////////////////////////////////////
    // apb master
    //////////////////////////////////////////////////////////////
    task automatic apb_transfer(input logic wr, input logic [1:0] region,
                                input logic [7:0] idx, input logic [31:0] wdata,
                                output logic [31:0] rdata, output logic err);
        int         waited;
        logic [1:0] low;
        waited = 0;
        step();
        low     = $random(seed);  // ignored by the decoder
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = {region, idx, low};
        pwdata  = wdata;
        step();
        penable = 1'b1;
        @(negedge clk);
        while (pready !== 1'b1 && waited <= APB_TIMEOUT)
        begin
            waited++;
            @(negedge clk);
        end
        if (pready !== 1'b1)
            report_timeout("pready");
        rdata = prdata;
        err   = pslverr;
        step();
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic cpu_read_check(input logic [1:0] region, input logic [7:0] idx);
        logic [31:0] rdata;
        logic        err;
        apb_transfer(1'b0, region, idx, 32'h0, rdata, err);
        check_value("prdata", rdata, expected_word(region, idx));
        check_value("pslverr", err, 1'b0);
    endtask

    task automatic cpu_write(input logic [1:0] region, input logic [7:0] idx,
                             input logic [31:0] w);
        logic [31:0] rdata;
        logic        err;
        apb_transfer(1'b1, region, idx, w, rdata, err);
        check_value("pslverr", err, 1'b0);
        apply_cpu_write(region, idx, w);
    endtask

    // apb access started under a burst of data path writes
    task automatic contention_round(input logic wr);
        logic [1:0]  region;
        logic [7:0]  idx;
        logic [7:0]  a;
        logic [31:0] w;
        logic [31:0] rdata;
        logic        err;
        buf_entry_t  e;
        int          n;
        region = $unsigned($random(seed)) % 3;
        idx    = $random(seed);
        w      = $random(seed);
        n      = 2 + $unsigned($random(seed)) % 6;
        fork
            begin
                for (int i = 0; i < n; i++)
                begin
                    a = (i == 0) ? idx : $random(seed);  // first beat hits the cpu slot
                    random_entry(e);
                    dp_write(a, e);
                    @(negedge clk);
                    check_value("pready", pready, 1'b0);
                end
                dp_release();
            end
            apb_transfer(wr, region, idx, w, rdata, err);
        join
        check_value("pslverr", err, 1'b0);
        if (wr)
            apply_cpu_write(region, idx, w);
        else
            check_value("prdata", rdata, expected_word(region, idx));
    endtask

    //////////////////////////////////////////////////////////////
    // sequence
    //////////////////////////////////////////////////////////////
    initial
    begin
        buf_entry_t  e;
        logic [1:0]  region;
        logic [7:0]  idx;
        logic [31:0] w;
        logic [31:0] rdata;
        logic        err;
        rstn     = 1'b0;
        wr_en    = 1'b0;
        wr_addr  = '0;
        wr_entry = '0;
        rd_addr  = '0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        repeat (8) @(posedge clk);
        #1;
        rstn = 1'b1;
        @(negedge clk);
        check_value("pready", pready, 1'b0);
        check_value("pslverr", pslverr, 1'b0);

        // fill every slot so the model is fully known
        for (int i = 0; i < `PB_DEPTH; i++)
        begin
            random_entry(e);
            dp_write(i, e);
        end
        dp_release();
        check_all_entries();

        for (int k = 0; k < 200; k++)
        begin
            random_entry(e);
            dp_write($random(seed), e);
        end
        dp_release();
        for (int k = 0; k < 100; k++)
            dp_read_check($random(seed));

        for (int k = 0; k < 60; k++)
        begin
            idx = $random(seed);
            for (int r = 0; r < 3; r++)
                cpu_read_check(r, idx);
        end

        for (int k = 0; k < 60; k++)
        begin
            region = $unsigned($random(seed)) % 3;
            idx    = $random(seed);
            w      = $random(seed);
            cpu_write(region, idx, w);
            dp_read_check(idx);
        end

        for (int k = 0; k < 8; k++)
            contention_round(k[0]);
        check_all_entries();

        // region 3 has no store behind it
        idx = $random(seed);
        apb_transfer(1'b0, 2'd3, idx, 32'h0, rdata, err);
        check_value("pslverr", err, 1'b1);
        apb_transfer(1'b1, 2'd3, idx, $random(seed), rdata, err);
        check_value("pslverr", err, 1'b1);
        check_all_entries();

        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- pkt_buffer_top.f
+incdir+design
design/pkt_buffer_pkg.sv
design/buffer_ram.sv
design/buffer_store.sv
design/cpu_access_ctrl.sv
design/pkt_buffer_top.sv
tb/pkt_buffer_tb.sv

//--- Bender.yml
package:
  name: pkt_buffer

sources:
  - include_dirs:
      - design
    files:
      - design/pkt_buffer_pkg.sv
      - design/buffer_ram.sv
      - design/buffer_store.sv
      - design/cpu_access_ctrl.sv
      - design/pkt_buffer_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - tb/pkt_buffer_tb.sv
